// File: te_packet_emitter.f
+incdir+tb
rtl/te_cfg_pkg.sv
rtl/te_packet_pkg.sv
rtl/te_req_stage.sv
rtl/te_addr_compress.sv
rtl/te_payload_builder.sv
rtl/te_out_stage.sv
rtl/te_packet_emitter.sv
tb/tb_te_packet_emitter.sv

// File: Makefile
TOP := tb_te_packet_emitter

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f te_packet_emitter.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f te_packet_emitter.f -o sim
	./obj_dir/sim

clean:
	rm -rf obj_dir

// File: tb/te_ref_model.svh
// reference model of the packet emitter
// byte compression, payload layout, latest address tracking
`ifndef TE_REF_MODEL_SVH
`define TE_REF_MODEL_SVH

te_cfg_pkg::addr_t         model_latest;
te_packet_pkg::te_packet_t exp_q[$];
te_cfg_pkg::payload_t      mp;
int unsigned               mpos;

// smallest byte count whose sign extension restores the value
function automatic int unsigned model_bytes(input logic [63:0] a);
    logic [63:0] sext;
    for (int unsigned n = 1; n < XLEN / 8; n++) begin
        sext = $signed(a << (64 - 8 * n)) >>> (64 - 8 * n);
        if (sext == a) begin
            return n;
        end
    end
    return XLEN / 8;
endfunction

// append w bits, lsb first
function automatic void emit(input logic [63:0] v, input int unsigned w);
    for (int unsigned i = 0; i < w; i++) begin
        mp[mpos+i] = v[i];
    end
    mpos += w;
endfunction

// compressed address plus notify, updiscon, irreport, irdepth
function automatic void emit_addr_tail(input te_packet_pkg::te_req_t r);
    logic [63:0] d;
    logic        ntf;
    logic        upd;
    if (r.ioptions == te_packet_pkg::FULL_ADDRESS) begin
        d = r.iaddr;
    end else begin
        d = r.iaddr - model_latest;
    end
    emit(d, 8 * model_bytes(d));
    ntf = r.iaddr[XLEN-1];
    upd = ntf ^ r.lc_updiscon;
    emit(ntf, 1);
    emit(upd, 1);
    emit(upd, 1);
    emit({upd, upd}, 2);
endfunction

// builds the expected packet for an accepted request
function automatic void model_accept(input te_packet_pkg::te_req_t r);
    te_packet_pkg::te_packet_t p;
    logic                      br;
    logic [63:0]               ta;
    int unsigned               w;
    mp = '0;
    mpos = 0;
    br = !(r.branch && r.branch_taken);
    emit(r.format, 2);
    if (r.format == te_packet_pkg::F_SYNC) begin
        emit(r.subformat, 2);
        p.ptype = te_packet_pkg::packet_type_e'(2 + r.subformat);
        if (r.subformat == te_packet_pkg::SF_START) begin
            emit(br, 1);
            emit(r.priv, 2);
            emit(r.iaddr, 8 * model_bytes(r.iaddr));
        end else if (r.subformat == te_packet_pkg::SF_TRAP) begin
            emit(br, 1);
            emit(r.priv, 2);
            emit(r.lc_tc_sel ? r.tc_cause : r.lc_cause, 5);
            emit(r.lc_tc_sel ? r.tc_interrupt : r.lc_interrupt, 1);
            emit(r.thaddr, 1);
            ta = r.thaddr ? {r.tvec[61:0], 2'b00} : r.epc;
            emit(ta, 8 * model_bytes(ta));
            emit(r.tval, XLEN);
        end else if (r.subformat == te_packet_pkg::SF_CONTEXT) begin
            emit(r.priv, 2);
        end else begin
            emit({r.ioptions, r.qual_status, r.encoder_mode, r.ienable}, 7);
        end
    end else if (r.format == te_packet_pkg::F_ADDR_ONLY) begin
        p.ptype = te_packet_pkg::PT_F2;
        emit_addr_tail(r);
    end else begin
        p.ptype = te_packet_pkg::PT_F1;
        emit(r.branches, 5);
        w = r.branches == 0 ? 0 : r.branches == 1 ? 1 : r.branches <= 9 ? 9 :
            r.branches <= 17 ? 17 : r.branches <= 25 ? 25 : 31;
        emit(r.branch_map, w);
        if (r.branches < 31) begin
            emit_addr_tail(r);
        end
    end
    p.payload = mp;
    p.length = te_cfg_pkg::payload_len_t'((mpos + 7) / 8);
    exp_q.push_back(p);
    // only address packets move the reference point
    if (r.format != te_packet_pkg::F_SYNC || r.subformat inside {te_packet_pkg::SF_START,
                                                              te_packet_pkg::SF_TRAP}) begin
        model_latest = r.iaddr;
    end
endfunction

`endif

// File: tb/tb_te_packet_emitter.sv
// testbench for the trace packet emitter
// random and directed requests, random back-pressure, model compare
`timescale 1ns/10ps
`default_nettype none

module tb_te_packet_emitter;

    localparam int unsigned XLEN = 64;

    logic                      clk_i;
    logic                      rst_ni;
    logic                      req_valid_i;
    te_packet_pkg::te_req_t    req_i;
    logic                      req_ready_o;
    logic                      pkt_valid_o;
    te_packet_pkg::te_packet_t pkt_o;
    logic                      pkt_ready_i;
    logic                      branch_map_flush_o;

    logic [63:0]               lcg_state = 64'd23319;
    logic [63:0]               prev_iaddr = '0;
    logic [63:0]               base_iaddr;
    int unsigned               map_counts[6] = '{0, 1, 9, 17, 25, 31};
    int                        ready_mode = 0;
    int unsigned               accepted = 0;
    int unsigned               flushes = 0;
    string                     test_name = "reset";
    te_packet_pkg::te_packet_t exp_pkt;
    te_packet_pkg::te_req_t    r;
    bit                        ok;
    int unsigned               acc0;

    `include "te_ref_model.svh"

    te_packet_emitter #(.XLEN(XLEN)) i_te_packet_emitter (
        .clk_i, .rst_ni, .req_valid_i, .req_i, .req_ready_o,
        .pkt_valid_o, .pkt_o, .pkt_ready_i, .branch_map_flush_o
    );

    function automatic logic [31:0] lcg();
        lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
        return lcg_state[63:32];
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_payload(input string name, input te_cfg_pkg::payload_t exp,
                                 input te_cfg_pkg::payload_t act);
        if (exp !== act) abort_run($sformatf("error %s payload: expected %h actual %h",
                                             name, exp, act));
    endtask

    task automatic check_length(input string name, input te_cfg_pkg::payload_len_t exp,
                                input te_cfg_pkg::payload_len_t act);
        if (exp !== act) abort_run($sformatf("error %s length: expected %0d actual %0d",
                                             name, exp, act));
    endtask

    task automatic check_type(input string name, input te_packet_pkg::packet_type_e exp,
                              input te_packet_pkg::packet_type_e act);
        if (exp !== act) abort_run($sformatf("error %s type: expected %s actual %s",
                                             name, exp.name(), act.name()));
    endtask

    // random request, addresses often near the previous one
    function automatic te_packet_pkg::te_req_t rand_req();
        te_packet_pkg::te_req_t q;
        logic [31:0]            v;
        q = '0;
        v = lcg();
        q.format = te_packet_pkg::format_e'(v % 3 + 1);
        q.subformat = te_packet_pkg::sync_subformat_e'(v[3:2]);
        q.lc_cause = v[8:4];
        q.tc_cause = v[13:9];
        q.lc_interrupt = v[14];
        q.tc_interrupt = v[15];
        q.lc_tc_sel = v[16];
        q.branch = v[17];
        q.branch_taken = v[18];
        q.priv = v[20:19];
        q.thaddr = v[21];
        q.ienable = v[22];
        q.encoder_mode = v[23];
        q.qual_status = te_packet_pkg::qual_status_e'(v[25:24]);
        q.ioptions = v[27:26] == 0 ? te_packet_pkg::FULL_ADDRESS : te_packet_pkg::DELTA_ADDRESS;
        q.lc_updiscon = v[28];
        q.iaddr = v[29] ? prev_iaddr + {{56{v[30]}}, 8'(lcg())} : {lcg(), lcg()};
        prev_iaddr = q.iaddr;
        q.tval = {lcg(), lcg()};
        q.tvec = {2'b00, 30'(lcg()), lcg()};
        q.epc = v[31] ? {32'd0, lcg() & 32'hfff} : {lcg(), lcg()};
        q.branches = 5'(lcg());
        q.branch_map = 31'(lcg());
        return q;
    endfunction

    // called at 1 ns after an edge, leaves valid high when not taken
    task automatic send_req(input te_packet_pkg::te_req_t q, input int unsigned limit,
                            output bit taken);
        int unsigned n;
        taken = 0;
        n = 0;
        req_i = q;
        req_valid_i = 1'b1;
        while (!taken && n < limit) begin
            @(negedge clk_i);
            taken = req_ready_o;
            @(posedge clk_i);
            #1;
            n++;
        end
        if (taken) begin
            model_accept(q);
            accepted++;
            req_valid_i = 1'b0;
        end
    endtask

    task automatic send_or_fail(input te_packet_pkg::te_req_t q);
        bit t;
        send_req(q, 200, t);
        if (!t) abort_run("request was not accepted within the timeout");
    endtask

    task automatic drain();
        int unsigned n;
        n = 0;
        while (exp_q.size() != 0 && n < 500) begin
            @(posedge clk_i);
            #1;
            n++;
        end
        if (exp_q.size() != 0) abort_run("expected packets never came out");
    endtask

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // back-pressure: 0 random, 1 held low
    initial begin
        pkt_ready_i = 1'b0;
        forever begin
            @(posedge clk_i);
            #1;
            pkt_ready_i = ready_mode == 1 ? 1'b0 : lcg() % 4 != 0;
        end
    end

    // output collection and flush counting
    initial begin
        forever begin
            @(negedge clk_i);
            if (rst_ni && branch_map_flush_o) flushes++;
            if (rst_ni && pkt_valid_o && pkt_ready_i) begin
                if (exp_q.size() == 0) abort_run("packet came out with none expected");
                exp_pkt = exp_q.pop_front();
                check_type(test_name, exp_pkt.ptype, pkt_o.ptype);
                check_length(test_name, exp_pkt.length, pkt_o.length);
                check_payload(test_name, exp_pkt.payload, pkt_o.payload);
            end
        end
    end

    initial begin
        #2000000;
        abort_run("simulation ran past its time limit");
    end

    initial begin
        rst_ni = 1'b0;
        req_valid_i = 1'b0;
        req_i = '0;
        model_latest = '0;
        repeat (2) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        // idle output until the first request
        test_name = "after_reset";
        repeat (4) begin
            @(negedge clk_i);
            if (pkt_valid_o || !req_ready_o) abort_run("outputs not idle after reset");
        end
        @(posedge clk_i);
        #1;
        r = rand_req();
        r.format = te_packet_pkg::F_ADDR_ONLY;
        r.ioptions = te_packet_pkg::DELTA_ADDRESS;
        send_or_fail(r);
        drain();
        // small address steps, then full address mode
        test_name = "diff_address";
        for (int i = 0; i < 8; i++) begin
            // step from the last address sent
            base_iaddr = prev_iaddr;
            r = rand_req();
            r.format = te_packet_pkg::format_e'(1 + i % 2);
            r.branches = 5'(i);
            r.iaddr = base_iaddr + 64'(4 * i);
            prev_iaddr = r.iaddr;
            r.ioptions = i >= 6 ? te_packet_pkg::FULL_ADDRESS : te_packet_pkg::DELTA_ADDRESS;
            send_or_fail(r);
        end
        test_name = "branch_map";
        foreach (map_counts[k]) begin
            r = rand_req();
            r.format = te_packet_pkg::F_DIFF_DELTA;
            r.branches = 5'(map_counts[k]);
            send_or_fail(r);
        end
        test_name = "trap";
        for (int i = 0; i < 4; i++) begin
            r = rand_req();
            r.format = te_packet_pkg::F_SYNC;
            r.subformat = te_packet_pkg::SF_TRAP;
            // lc and tc always differ
            r.tc_cause = ~r.lc_cause;
            r.tc_interrupt = ~r.lc_interrupt;
            r.lc_tc_sel = i[0];
            r.thaddr = i[1];
            send_or_fail(r);
        end
        test_name = "random";
        for (int i = 0; i < 400; i++) begin
            send_or_fail(rand_req());
        end
        drain();
        // long stall: two entries fill, the third waits
        test_name = "stall";
        ready_mode = 1;
        @(posedge clk_i);
        #1;
        acc0 = accepted;
        for (int i = 0; i < 3; i++) begin
            r = rand_req();
            send_req(r, 20, ok);
        end
        if (accepted - acc0 != 2) abort_run("stall did not stop input after two requests");
        ready_mode = 0;
        send_or_fail(r);
        drain();
        repeat (3) @(posedge clk_i);
        if (flushes != accepted) begin
            abort_run("flush pulse count differs from accepted count");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: rtl/te_packet_emitter.sv
// trace packet emitter top level
// input register, address compression and payload builder, output register
`timescale 1ns/10ps
`default_nettype none

module te_packet_emitter #(
    parameter int unsigned XLEN = 64
) (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      req_valid_i,
    input  te_packet_pkg::te_req_t    req_i,
    output logic                      req_ready_o,
    output logic                      pkt_valid_o,
    output te_packet_pkg::te_packet_t pkt_o,
    input  logic                      pkt_ready_i,
    output logic                      branch_map_flush_o
);

    logic                      hold_valid;
    logic                      hold_ready;
    te_packet_pkg::te_req_t    hold;
    te_cfg_pkg::addr_t         diff_addr;
    te_cfg_pkg::payload_len_t  diff_bytes;
    te_cfg_pkg::payload_len_t  abs_bytes;
    te_cfg_pkg::payload_len_t  trap_bytes;
    te_packet_pkg::te_packet_t pkt_built;
    logic                      commit;

    te_req_stage i_te_req_stage (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .req_valid_i        (req_valid_i),
        .req_i              (req_i),
        .req_ready_o        (req_ready_o),
        .hold_valid_o       (hold_valid),
        .hold_o             (hold),
        .hold_ready_i       (hold_ready),
        .branch_map_flush_o (branch_map_flush_o)
    );

    // latest address moves on the output load strobe
    te_addr_compress #(
        .XLEN (XLEN)
    ) i_te_addr_compress (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .hold_i       (hold),
        .commit_i     (commit),
        .diff_addr_o  (diff_addr),
        .diff_bytes_o (diff_bytes),
        .abs_bytes_o  (abs_bytes),
        .trap_bytes_o (trap_bytes)
    );

    te_payload_builder #(
        .XLEN (XLEN)
    ) i_te_payload_builder (
        .hold_i       (hold),
        .diff_addr_i  (diff_addr),
        .diff_bytes_i (diff_bytes),
        .abs_bytes_i  (abs_bytes),
        .trap_bytes_i (trap_bytes),
        .pkt_o        (pkt_built)
    );

    te_out_stage i_te_out_stage (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .in_valid_i  (hold_valid),
        .in_ready_o  (hold_ready),
        .pkt_i       (pkt_built),
        .commit_o    (commit),
        .pkt_valid_o (pkt_valid_o),
        .pkt_o       (pkt_o),
        .pkt_ready_i (pkt_ready_i)
    );

endmodule

`default_nettype wire

// File: rtl/te_out_stage.sv
// one-entry output register for finished packets
`timescale 1ns/10ps
`default_nettype none

module te_out_stage (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      in_valid_i,
    output logic                      in_ready_o,
    input  te_packet_pkg::te_packet_t pkt_i,
    output logic                      commit_o,
    output logic                      pkt_valid_o,
    output te_packet_pkg::te_packet_t pkt_o,
    input  logic                      pkt_ready_i
);

    // empty, or the current packet leaves this cycle
    assign in_ready_o = ~pkt_valid_o | pkt_ready_i;
    // load strobe, also moves the latest address
    assign commit_o = in_valid_i & in_ready_o;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pkt_valid_o <= 1'b0;
        end else if (in_ready_o) begin
            pkt_valid_o <= in_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (commit_o) begin
            pkt_o <= pkt_i;
        end
    end

    // stalled packet holds until the consumer takes it
    a_out_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
        pkt_valid_o && !pkt_ready_i |=> pkt_valid_o && $stable(pkt_o))
        else $error("packet changed while stalled");

    // format 0 requests are not supported upstream
    a_no_format0 : assert property (@(posedge clk_i) disable iff (!rst_ni)
        in_valid_i |-> pkt_i.payload[1:0] != 2'(te_packet_pkg::F_OPT_EXT))
        else $error("format 0 request reached the output");

endmodule

`default_nettype wire

// File: rtl/te_payload_builder.sv
// payload layout, packet type and byte length
// for F1, F2 and the four F3 subformats
`timescale 1ns/10ps
`default_nettype none

module te_payload_builder #(
    parameter int unsigned XLEN = 64
) (
    input  te_packet_pkg::te_req_t    hold_i,
    input  te_cfg_pkg::addr_t         diff_addr_i,
    input  te_cfg_pkg::payload_len_t  diff_bytes_i,
    input  te_cfg_pkg::payload_len_t  abs_bytes_i,
    input  te_cfg_pkg::payload_len_t  trap_bytes_i,
    output te_packet_pkg::te_packet_t pkt_o
);

    // notify, updiscon, irreport, then irdepth
    localparam int unsigned TAIL_LEN = 3 + te_cfg_pkg::IRDEPTH_LEN;
    localparam int unsigned SF0_LEN = 1 + te_cfg_pkg::PRIV_LEN;
    localparam int unsigned SF1_LEN = 3 + te_cfg_pkg::PRIV_LEN + te_cfg_pkg::CAUSE_LEN;

    logic                 branch;
    logic                 notify;
    logic                 updiscon;
    logic [TAIL_LEN-1:0]  tail;
    te_cfg_pkg::cause_t   ecause;
    logic                 interrupt;
    te_cfg_pkg::addr_t    trap_addr;
    int unsigned          map_len;
    int unsigned          diff_bits;
    int unsigned          abs_bits;
    int unsigned          trap_bits;
    int unsigned          pos;
    te_cfg_pkg::payload_t payload;

    // place the low w bits of v at bit position at
    function automatic te_cfg_pkg::payload_t put(
        input te_cfg_pkg::payload_t p,
        input int unsigned          at,
        input te_cfg_pkg::payload_t v,
        input int unsigned          w
    );
        te_cfg_pkg::payload_t mask;
        mask = (te_cfg_pkg::payload_t'(1) << w) - te_cfg_pkg::payload_t'(1);
        return p | ((v & mask) << at);
    endfunction

    // 0 when the branch was taken
    assign branch = ~(hold_i.branch & hold_i.branch_taken);
    assign ecause = hold_i.lc_tc_sel ? hold_i.tc_cause : hold_i.lc_cause;
    assign interrupt = hold_i.lc_tc_sel ? hold_i.tc_interrupt : hold_i.lc_interrupt;
    assign trap_addr = hold_i.thaddr ? hold_i.tvec << 2 : hold_i.epc;

    // no trigger unit and no implicit return
    assign notify = hold_i.iaddr[XLEN-1];
    assign updiscon = notify ^ hold_i.lc_updiscon;
    assign tail = {{te_cfg_pkg::IRDEPTH_LEN{updiscon}}, updiscon, updiscon, notify};

    assign diff_bits = 8 * diff_bytes_i;
    assign abs_bits = 8 * abs_bytes_i;
    assign trap_bits = 8 * trap_bytes_i;

    // smallest map width holding the count
    always_comb begin
        case (hold_i.branches) inside
            5'd0: map_len = 0;
            5'd1: map_len = 1;
            [5'd2:5'd9]: map_len = 9;
            [5'd10:5'd17]: map_len = 17;
            [5'd18:5'd25]: map_len = 25;
            default: map_len = 31;
        endcase
    end

    always_comb begin
        payload = '0;
        pos = 0;
        pkt_o.ptype = te_packet_pkg::PT_F1;
        // every packet opens with the format
        payload = put(payload, pos, te_cfg_pkg::payload_t'(hold_i.format), 2);
        pos += 2;
        case (hold_i.format)
            te_packet_pkg::F_SYNC: begin
                payload = put(payload, pos, te_cfg_pkg::payload_t'(hold_i.subformat), 2);
                pos += 2;
                case (hold_i.subformat)
                    te_packet_pkg::SF_START: begin
                        pkt_o.ptype = te_packet_pkg::PT_F3SF0;
                        payload = put(payload, pos,
                                      te_cfg_pkg::payload_t'({hold_i.priv, branch}), SF0_LEN);
                        pos += SF0_LEN;
                        // absolute address, compressed
                        payload = put(payload, pos, te_cfg_pkg::payload_t'(hold_i.iaddr),
                                      abs_bits);
                        pos += abs_bits;
                    end
                    te_packet_pkg::SF_TRAP: begin
                        pkt_o.ptype = te_packet_pkg::PT_F3SF1;
                        payload = put(payload, pos,
                                      te_cfg_pkg::payload_t'({hold_i.thaddr, interrupt, ecause,
                                                              hold_i.priv, branch}), SF1_LEN);
                        pos += SF1_LEN;
                        payload = put(payload, pos, te_cfg_pkg::payload_t'(trap_addr), trap_bits);
                        pos += trap_bits;
                        // tval always full width
                        payload = put(payload, pos, te_cfg_pkg::payload_t'(hold_i.tval), XLEN);
                        pos += XLEN;
                    end
                    te_packet_pkg::SF_CONTEXT: begin
                        pkt_o.ptype = te_packet_pkg::PT_F3SF2;
                        payload = put(payload, pos, te_cfg_pkg::payload_t'(hold_i.priv),
                                      te_cfg_pkg::PRIV_LEN);
                        pos += te_cfg_pkg::PRIV_LEN;
                    end
                    default: begin
                        pkt_o.ptype = te_packet_pkg::PT_F3SF3;
                        payload = put(payload, pos,
                                      te_cfg_pkg::payload_t'({hold_i.ioptions, hold_i.qual_status,
                                                              hold_i.encoder_mode,
                                                              hold_i.ienable}), 7);
                        pos += 7;
                    end
                endcase
            end
            te_packet_pkg::F_ADDR_ONLY: begin
                pkt_o.ptype = te_packet_pkg::PT_F2;
                payload = put(payload, pos, te_cfg_pkg::payload_t'(diff_addr_i), diff_bits);
                pos += diff_bits;
                payload = put(payload, pos, te_cfg_pkg::payload_t'(tail), TAIL_LEN);
                pos += TAIL_LEN;
            end
            // format 1, format 0 lands here as well
            default: begin
                payload = put(payload, pos, te_cfg_pkg::payload_t'(hold_i.branches),
                              te_cfg_pkg::BRANCH_COUNT_LEN);
                pos += te_cfg_pkg::BRANCH_COUNT_LEN;
                payload = put(payload, pos, te_cfg_pkg::payload_t'(hold_i.branch_map), map_len);
                pos += map_len;
                // full map means no address
                if (hold_i.branches < 5'd31) begin
                    payload = put(payload, pos, te_cfg_pkg::payload_t'(diff_addr_i), diff_bits);
                    pos += diff_bits;
                    payload = put(payload, pos, te_cfg_pkg::payload_t'(tail), TAIL_LEN);
                    pos += TAIL_LEN;
                end
            end
        endcase
        pkt_o.payload = payload;
        // round up to whole bytes
        pkt_o.length = te_cfg_pkg::payload_len_t'((pos + 7) / 8);
    end

endmodule

`default_nettype wire

// File: rtl/te_addr_compress.sv
// latest emitted address register
// differential and trap address, byte counts by sign extension
`timescale 1ns/10ps
`default_nettype none

module te_addr_compress #(
    parameter int unsigned XLEN = 64
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  te_packet_pkg::te_req_t   hold_i,
    input  logic                     commit_i,
    output te_cfg_pkg::addr_t        diff_addr_o,
    output te_cfg_pkg::payload_len_t diff_bytes_o,
    output te_cfg_pkg::payload_len_t abs_bytes_o,
    output te_cfg_pkg::payload_len_t trap_bytes_o
);

    localparam int unsigned XBYTES = XLEN / 8;
    localparam te_cfg_pkg::addr_t ADDR_MASK = te_cfg_pkg::addr_t'({XLEN{1'b1}});

    te_cfg_pkg::addr_t latest_q;
    te_cfg_pkg::addr_t trap_addr;
    logic              addr_pkt;

    // fewest low bytes whose top bit sign-extends to the whole value
    function automatic te_cfg_pkg::payload_len_t byte_count(input te_cfg_pkg::addr_t a);
        te_cfg_pkg::payload_len_t n;
        logic                     fits;
        n = te_cfg_pkg::payload_len_t'(XBYTES);
        // fitting is monotone, so the last hit going down is the smallest
        for (int k = XBYTES - 1; k >= 1; k--) begin
            fits = 1'b1;
            for (int b = 8 * k - 1; b < XLEN; b++) begin
                if (a[b] != a[XLEN-1]) begin
                    fits = 1'b0;
                end
            end
            if (fits) begin
                n = te_cfg_pkg::payload_len_t'(k);
            end
        end
        return n;
    endfunction

    // full address mode sends iaddr as is
    always_comb begin
        if (hold_i.ioptions == te_packet_pkg::FULL_ADDRESS) begin
            diff_addr_o = hold_i.iaddr & ADDR_MASK;
        end else begin
            diff_addr_o = (hold_i.iaddr - latest_q) & ADDR_MASK;
        end
    end

    // tvec gets two zero bits appended
    assign trap_addr = (hold_i.thaddr ? hold_i.tvec << 2 : hold_i.epc) & ADDR_MASK;

    assign diff_bytes_o = byte_count(diff_addr_o);
    assign abs_bytes_o = byte_count(hold_i.iaddr);
    assign trap_bytes_o = byte_count(trap_addr);

    // packets that carry iaddr: F1, F2, F3SF0 and F3SF1
    assign addr_pkt = (hold_i.format == te_packet_pkg::F_DIFF_DELTA) ||
                      (hold_i.format == te_packet_pkg::F_ADDR_ONLY) ||
                      ((hold_i.format == te_packet_pkg::F_SYNC) &&
                       (hold_i.subformat inside {te_packet_pkg::SF_START,
                                                 te_packet_pkg::SF_TRAP}));

    // follows the packets as they enter the output register
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            latest_q <= '0;
        end else if (commit_i && addr_pkt) begin
            latest_q <= hold_i.iaddr & ADDR_MASK;
        end
    end

    a_bytes_range : assert property (@(posedge clk_i) disable iff (!rst_ni)
        commit_i |-> diff_bytes_o inside {[1:XBYTES]} &&
                     abs_bytes_o inside {[1:XBYTES]} &&
                     trap_bytes_o inside {[1:XBYTES]})
        else $error("address byte count out of range");

endmodule

`default_nettype wire

// File: rtl/te_req_stage.sv
// one-entry input register for packet requests
// flush pulse for the branch map after each accepted request
`timescale 1ns/10ps
`default_nettype none

module te_req_stage (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   req_valid_i,
    input  te_packet_pkg::te_req_t req_i,
    output logic                   req_ready_o,
    output logic                   hold_valid_o,
    output te_packet_pkg::te_req_t hold_o,
    input  logic                   hold_ready_i,
    output logic                   branch_map_flush_o
);

    logic accept;

    // empty, or the held request moves on this cycle
    assign req_ready_o = ~hold_valid_o | hold_ready_i;
    assign accept = req_valid_i & req_ready_o;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            hold_valid_o <= 1'b0;
            branch_map_flush_o <= 1'b0;
        end else begin
            if (req_ready_o) begin
                hold_valid_o <= req_valid_i;
            end
            // one cycle after the transfer
            branch_map_flush_o <= accept;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            hold_o <= req_i;
        end
    end

    // a stalled request stays put until taken
    a_req_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
        req_valid_i && !req_ready_o |=> req_valid_i && $stable(req_i))
        else $error("request changed while stalled");

endmodule

`default_nettype wire

// File: rtl/te_packet_pkg.sv
// packet format, subformat and type encodings
// request and finished packet structs
`default_nettype none

package te_packet_pkg;

    typedef enum logic [1:0] {
        F_OPT_EXT    = 2'd0,
        F_DIFF_DELTA = 2'd1,
        F_ADDR_ONLY  = 2'd2,
        F_SYNC       = 2'd3
    } format_e;

    // subformats of format 3
    typedef enum logic [1:0] {
        SF_START   = 2'd0,
        SF_TRAP    = 2'd1,
        SF_CONTEXT = 2'd2,
        SF_SUPPORT = 2'd3
    } sync_subformat_e;

    typedef enum logic [2:0] {
        PT_F1    = 3'd0,
        PT_F2    = 3'd1,
        PT_F3SF0 = 3'd2,
        PT_F3SF1 = 3'd3,
        PT_F3SF2 = 3'd4,
        PT_F3SF3 = 3'd5
    } packet_type_e;

    typedef enum logic [1:0] {
        QS_NO_CHANGE  = 2'd0,
        QS_ENDED_REP  = 2'd1,
        QS_TRACE_LOST = 2'd2,
        QS_ENDED_NTR  = 2'd3
    } qual_status_e;

    typedef enum logic [2:0] {
        DELTA_ADDRESS      = 3'd0,
        FULL_ADDRESS       = 3'd1,
        IMPLICIT_EXCEPTION = 3'd2,
        SIJUMP             = 3'd3,
        IMPLICIT_RETURN    = 3'd4,
        BRANCH_PREDICTION  = 3'd5,
        JUMP_TARGET_CACHE  = 3'd6
    } ioptions_e;

    // one packet request
    typedef struct packed {
        format_e                   format;
        sync_subformat_e           subformat;
        te_cfg_pkg::cause_t        lc_cause;
        te_cfg_pkg::cause_t        tc_cause;
        te_cfg_pkg::addr_t         tval;
        logic                      lc_interrupt;
        logic                      tc_interrupt;
        // picks tc over lc for cause and interrupt
        logic                      lc_tc_sel;
        logic                      branch;
        logic                      branch_taken;
        te_cfg_pkg::priv_t         priv;
        te_cfg_pkg::addr_t         iaddr;
        logic                      thaddr;
        // trap vector bits XLEN-1:2, held right aligned
        te_cfg_pkg::addr_t         tvec;
        te_cfg_pkg::addr_t         epc;
        logic                      ienable;
        logic                      encoder_mode;
        qual_status_e              qual_status;
        ioptions_e                 ioptions;
        logic                      lc_updiscon;
        te_cfg_pkg::branch_count_t branches;
        te_cfg_pkg::branch_map_t   branch_map;
    } te_req_t;

    // finished packet
    typedef struct packed {
        packet_type_e             ptype;
        te_cfg_pkg::payload_t     payload;
        te_cfg_pkg::payload_len_t length;
    } te_packet_t;

endpackage

`default_nettype wire

// File: rtl/te_cfg_pkg.sv
// field widths for the trace packet emitter
// plain vector types for addresses, causes, branches and payload
`default_nettype none

package te_cfg_pkg;

    // widest supported address
    localparam int unsigned XLEN_MAX = 64;
    // exception cause and privilege
    localparam int unsigned CAUSE_LEN = 5;
    localparam int unsigned PRIV_LEN = 2;
    // branch count and map of format 1
    localparam int unsigned BRANCH_COUNT_LEN = 5;
    localparam int unsigned BRANCH_MAP_LEN = 31;
    // irdepth bits in the address tail
    localparam int unsigned IRDEPTH_LEN = 2;
    // longest packet is F3SF1 at 142 bits with XLEN 64
    localparam int unsigned PAYLOAD_LEN = 160;
    // payload length counted in bytes
    localparam int unsigned LEN_W = 5;

    typedef logic [CAUSE_LEN-1:0] cause_t;
    typedef logic [PRIV_LEN-1:0] priv_t;
    typedef logic [BRANCH_COUNT_LEN-1:0] branch_count_t;
    typedef logic [BRANCH_MAP_LEN-1:0] branch_map_t;
    typedef logic [PAYLOAD_LEN-1:0] payload_t;
    typedef logic [LEN_W-1:0] payload_len_t;

    // only the low XLEN bits are live, the rest stay zero
    typedef logic [XLEN_MAX-1:0] addr_t;

endpackage

`default_nettype wire
